//--- logic/axil_pkg.sv
// AXI4-Lite channel payloads and response codes.
// shared by the host-facing paths and the top level.
`default_nettype none

`include "ni_csr_cfg.svh"

package axil_pkg;

  // bresp / rresp encodings, only the two we return.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // write address channel.
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
  } axil_aw_t;

  // write data channel.
  // strb is carried but writes are always full word.
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0]   data;
    logic [`AXIL_DATA_W/8-1:0] strb;
  } axil_w_t;

  // write response channel.
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  // read address channel.
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
  } axil_ar_t;

  // read data channel.
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    axil_resp_e              resp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- logic/axil_rd_path.sv
// AXI4-Lite read side: takes AR, issues one CSR read, holds R until taken.
// arready stays low while a read is outstanding.
`timescale 1ns/1ps
`default_nettype none

`include "ni_csr_cfg.svh"

module axil_rd_path
  import axil_pkg::*;
  import ni_csr_pkg::*;
(
  input  wire       clk_axi,
  input  wire       arst_axi,
  // ar channel.
  input  wire       ar_valid_i,
  input  axil_ar_t  ar_i,
  output logic      ar_ready_o,
  // r channel.
  output logic      r_valid_o,
  output axil_r_t   r_o,
  input  wire       r_ready_i,
  // towards the register block.
  output csr_req_t  csr_req_o,
  input  wire       grant_i,
  input  wire       resp_valid_i,
  input  csr_resp_t resp_i
);

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_RESP} rd_state_e;

  rd_state_e               state_q, state_d;
  logic                    ar_hs;
  logic [`AXIL_ADDR_W-1:0] addr_q;
  csr_resp_t               resp_q;
  csr_resp_t               resp_cur;

  assign ar_ready_o = (state_q == RD_IDLE);
  assign ar_hs      = ar_valid_i && ar_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (ar_hs) state_d = RD_REQ;
      RD_REQ:  if (grant_i) state_d = RD_RESP;
      RD_RESP: if (r_ready_i) state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) state_q <= RD_IDLE;
    else state_q <= state_d;
  end

  // address and returned word, no reset.
  always_ff @(posedge clk_axi) begin
    if (ar_hs) addr_q <= ar_i.addr;
    if (resp_valid_i) resp_q <= resp_i;
  end

  always_comb begin
    csr_req_o.valid = (state_q == RD_REQ);
    csr_req_o.wr    = 1'b0;
    csr_req_o.addr  = addr_q;
    csr_req_o.wdata = '0;
  end

  // live answer in the first cycle, held copy under back-pressure.
  assign resp_cur  = resp_valid_i ? resp_i : resp_q;
  assign r_valid_o = (state_q == RD_RESP);
  // erroring reads always return zero data.
  assign r_o.data  = resp_cur.err ? '0 : resp_cur.rdata;
  assign r_o.resp  = resp_cur.err ? SLVERR : OKAY;

endmodule

`default_nettype wire

//--- logic/axil_wr_path.sv
// AXI4-Lite write side: collects AW and W, issues one CSR write, answers on B.
// one write in flight at a time.
`timescale 1ns/1ps
`default_nettype none

`include "ni_csr_cfg.svh"

module axil_wr_path
  import axil_pkg::*;
  import ni_csr_pkg::*;
(
  input  wire       clk_axi,
  input  wire       arst_axi,
  // aw channel.
  input  wire       aw_valid_i,
  input  axil_aw_t  aw_i,
  output logic      aw_ready_o,
  // w channel.
  input  wire       w_valid_i,
  input  axil_w_t   w_i,
  output logic      w_ready_o,
  // b channel.
  output logic      b_valid_o,
  output axil_b_t   b_o,
  input  wire       b_ready_i,
  // towards the register block.
  output csr_req_t  csr_req_o,
  input  wire       grant_i,
  input  wire       resp_valid_i,
  input  csr_resp_t resp_i
);

  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_e;

  wr_state_e               state_q, state_d;
  logic                    aw_got_q, w_got_q;
  logic                    aw_hs, w_hs;
  logic [`AXIL_ADDR_W-1:0] addr_q;
  logic [`AXIL_DATA_W-1:0] data_q;
  logic                    err_q;
  logic                    err_cur;

  // each channel is open until its beat is taken.
  assign aw_ready_o = (state_q == WR_IDLE) && !aw_got_q;
  assign w_ready_o  = (state_q == WR_IDLE) && !w_got_q;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if ((aw_got_q || aw_hs) && (w_got_q || w_hs)) state_d = WR_REQ;
      WR_REQ:  if (grant_i) state_d = WR_RESP;
      WR_RESP: if (b_ready_i) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      state_q  <= WR_IDLE;
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // flags drop once the request goes out.
      if (state_d == WR_REQ) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        aw_got_q <= aw_got_q | aw_hs;
        w_got_q  <= w_got_q | w_hs;
      end
    end
  end

  // payload capture.
  always_ff @(posedge clk_axi) begin
    if (aw_hs) addr_q <= aw_i.addr;
    if (w_hs) data_q <= w_i.data;
    if (resp_valid_i) err_q <= resp_i.err;
  end

  always_comb begin
    csr_req_o.valid = (state_q == WR_REQ);
    csr_req_o.wr    = 1'b1;
    csr_req_o.addr  = addr_q;
    csr_req_o.wdata = data_q;
  end

  // first response cycle uses the live answer, later ones the held copy.
  assign err_cur   = resp_valid_i ? resp_i.err : err_q;
  assign b_valid_o = (state_q == WR_RESP);
  assign b_o.resp  = err_cur ? SLVERR : OKAY;

endmodule

`default_nettype wire

//--- logic/ni_csr_cfg.svh
// build-time constants of the network interface CSR block.
// included by both packages, the RTL and the testbench.
`ifndef NI_CSR_CFG_SVH
`define NI_CSR_CFG_SVH

// ********************************************************************
// noc side
// ********************************************************************
// virtual channels per input port.
`define NOC_NUM_VC    3
// receive buffer occupancy count.
`define NOC_OCUP_W    16
// packet size at buffer head.
`define NOC_PKT_W     8
// router x / y coordinate.
`define NOC_ID_W      4

// ********************************************************************
// host side
// ********************************************************************
`define AXIL_ADDR_W   16
`define AXIL_DATA_W   32
// register window, sized to the address width.
`define CSR_BASE_ADDR 16'h1000
`define CSR_WIN_BYTES 16'h0040
// "NI" tag in the upper half, release 1.2 below.
`define NOC_VERSION   32'h4e49_0102

`endif

//--- logic/ni_csr_pkg.sv
// register map, internal CSR request/response and NoC status types.
// used by the two AXI paths, the register block and the top level.
`default_nettype none

`include "ni_csr_cfg.svh"

package ni_csr_pkg;

  // one access from a path to the register block.
  typedef struct packed {
    logic                    valid;
    logic                    wr;     // 1 = write.
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] wdata;
  } csr_req_t;

  // registered answer, one cycle after grant.
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] rdata;
    logic                    err;
  } csr_resp_t;

  // byte offsets from the window base.
  // pkt size of vc i lives at CSR_PKT_SIZE_VC0 + 4*i.
  typedef enum logic [`AXIL_ADDR_W-1:0] {
    CSR_VERSION      = 'h00,
    CSR_ROUTER_X     = 'h04,
    CSR_ROUTER_Y     = 'h08,
    CSR_IRQ_STATUS   = 'h0C,
    CSR_IRQ_SRC      = 'h10,
    CSR_IRQ_MASK     = 'h14,
    CSR_PKT_SIZE_VC0 = 'h18
  } csr_off_e;

  // what drives the per-vc interrupt bit.
  typedef enum logic [1:0] {
    IRQ_NOT_EMPTY    = 2'd0,
    IRQ_EMPTY_MASKED = 2'd1,
    IRQ_FULL_MASKED  = 2'd2,
    IRQ_OCUP_THRESH  = 2'd3
  } irq_src_e;

  // receive buffer state, one entry per vc.
  typedef struct packed {
    logic [`NOC_NUM_VC-1:0]                  empty;
    logic [`NOC_NUM_VC-1:0]                  full;
    logic [`NOC_NUM_VC-1:0][`NOC_OCUP_W-1:0] ocup;
    logic [`NOC_NUM_VC-1:0][`NOC_PKT_W-1:0]  pkt_size;
  } vc_status_t;

  typedef struct packed {
    logic [`NOC_NUM_VC-1:0] irq_vcs;
    logic                   irq_trig;
  } ni_irq_t;

endpackage

`default_nettype wire

//--- logic/ni_csr_regs.sv
// NI register file: read-over-write arbitration, decode and interrupt logic.
// answers one request per cycle, response registered for the next cycle.
`timescale 1ns/1ps
`default_nettype none

`include "ni_csr_cfg.svh"

module ni_csr_regs
  import ni_csr_pkg::*;
#(
  parameter logic [`NOC_ID_W-1:0] ROUTER_X_ID = '0,
  parameter logic [`NOC_ID_W-1:0] ROUTER_Y_ID = '0
) (
  input  wire        clk_axi,
  input  wire        arst_axi,
  input  csr_req_t   rd_req_i,
  input  csr_req_t   wr_req_i,
  output logic       rd_grant_o,
  output logic       wr_grant_o,
  output logic       rd_resp_valid_o,
  output logic       wr_resp_valid_o,
  output csr_resp_t  resp_o,
  input  vc_status_t vc_status_i,
  output ni_irq_t    irq_o
);

  csr_req_t                sel_req;
  logic [`AXIL_ADDR_W-1:0] off;
  logic                    bad_addr;
  logic [`AXIL_DATA_W-1:0] rd_data;
  logic                    err;
  irq_src_e                src_q, src_d;
  logic [`AXIL_DATA_W-1:0] mask_q, mask_d;
  csr_resp_t               resp_q;

  // ********************************************************************
  // arbitration
  // ********************************************************************
  // read wins, a read never asks two cycles in a row.
  assign rd_grant_o = rd_req_i.valid;
  assign wr_grant_o = wr_req_i.valid && !rd_req_i.valid;
  assign sel_req    = rd_req_i.valid ? rd_req_i : wr_req_i;

  // offset inside the window.
  assign off      = sel_req.addr - `CSR_BASE_ADDR;
  assign bad_addr = (sel_req.addr < `CSR_BASE_ADDR) || (off >= `CSR_WIN_BYTES) ||
                    (off[1:0] != 2'b00);

  // ********************************************************************
  // decode
  // ********************************************************************
  always_comb begin
    rd_data = '0;
    err     = 1'b0;
    src_d   = src_q;
    mask_d  = mask_q;
    if (sel_req.valid) begin
      if (bad_addr) begin
        err = 1'b1;
      end else if (sel_req.wr) begin
        // only source and mask are writable.
        case (off)
          CSR_IRQ_SRC:  src_d = irq_src_e'(sel_req.wdata[1:0]);
          CSR_IRQ_MASK: mask_d = sel_req.wdata;
          default:      err = 1'b1;
        endcase
      end else begin
        case (off)
          CSR_VERSION:    rd_data = `NOC_VERSION;
          CSR_ROUTER_X:   rd_data = `AXIL_DATA_W'(ROUTER_X_ID);
          CSR_ROUTER_Y:   rd_data = `AXIL_DATA_W'(ROUTER_Y_ID);
          CSR_IRQ_STATUS: rd_data = `AXIL_DATA_W'(irq_o.irq_vcs);
          CSR_IRQ_SRC:    rd_data = `AXIL_DATA_W'(src_q);
          CSR_IRQ_MASK:   rd_data = mask_q;
          default: begin
            // per-vc packet size words, else unmapped.
            err = 1'b1;
            for (int i = 0; i < `NOC_NUM_VC; i++) begin
              if (off == `AXIL_ADDR_W'(CSR_PKT_SIZE_VC0 + 4 * i)) begin
                rd_data = `AXIL_DATA_W'(vc_status_i.pkt_size[i]);
                err     = 1'b0;
              end
            end
          end
        endcase
      end
    end
  end

  // control state.
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      rd_resp_valid_o <= 1'b0;
      wr_resp_valid_o <= 1'b0;
      src_q           <= IRQ_NOT_EMPTY;
      mask_q          <= '1;
    end else begin
      rd_resp_valid_o <= rd_grant_o;
      wr_resp_valid_o <= wr_grant_o;
      src_q           <= src_d;
      mask_q          <= mask_d;
    end
  end

  // response word, only loaded on a grant.
  always_ff @(posedge clk_axi) begin
    if (sel_req.valid) begin
      resp_q.rdata <= rd_data;
      resp_q.err   <= err;
    end
  end

  assign resp_o = resp_q;

  // ********************************************************************
  // interrupts
  // ********************************************************************
  always_comb begin
    irq_o = '0;
    for (int i = 0; i < `NOC_NUM_VC; i++) begin
      case (src_q)
        IRQ_NOT_EMPTY:    irq_o.irq_vcs[i] = !vc_status_i.empty[i];
        IRQ_EMPTY_MASKED: irq_o.irq_vcs[i] = !vc_status_i.empty[i] && mask_q[i];
        IRQ_FULL_MASKED:  irq_o.irq_vcs[i] = vc_status_i.full[i] && mask_q[i];
        // mask acts as occupancy threshold here.
        IRQ_OCUP_THRESH:  irq_o.irq_vcs[i] =
                            (vc_status_i.ocup[i] >= mask_q[`NOC_OCUP_W-1:0]);
        default:          irq_o.irq_vcs[i] = !vc_status_i.empty[i];
      endcase
    end
    irq_o.irq_trig = |irq_o.irq_vcs;
  end

endmodule

`default_nettype wire

//--- logic/ni_csr_top.sv
// NI control/status top: AXI4-Lite slave in front of the register file.
// write and read paths share the register block.
`timescale 1ns/1ps
`default_nettype none

`include "ni_csr_cfg.svh"

module ni_csr_top
  import axil_pkg::*;
  import ni_csr_pkg::*;
#(
  parameter logic [`NOC_ID_W-1:0] ROUTER_X_ID = '0,
  parameter logic [`NOC_ID_W-1:0] ROUTER_Y_ID = '0
) (
  input  wire        clk_axi,
  input  wire        arst_axi,
  input  wire        aw_valid_i,
  input  axil_aw_t   aw_i,
  output logic       aw_ready_o,
  input  wire        w_valid_i,
  input  axil_w_t    w_i,
  output logic       w_ready_o,
  output logic       b_valid_o,
  output axil_b_t    b_o,
  input  wire        b_ready_i,
  input  wire        ar_valid_i,
  input  axil_ar_t   ar_i,
  output logic       ar_ready_o,
  output logic       r_valid_o,
  output axil_r_t    r_o,
  input  wire        r_ready_i,
  input  vc_status_t vc_status_i,
  output ni_irq_t    irq_o
);

  csr_req_t  wr_req, rd_req;
  logic      wr_grant, rd_grant;
  logic      wr_resp_valid, rd_resp_valid;
  csr_resp_t csr_resp;

  axil_wr_path i_axil_wr_path (
    .clk_axi      (clk_axi),
    .arst_axi     (arst_axi),
    .aw_valid_i   (aw_valid_i),
    .aw_i         (aw_i),
    .aw_ready_o   (aw_ready_o),
    .w_valid_i    (w_valid_i),
    .w_i          (w_i),
    .w_ready_o    (w_ready_o),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o),
    .b_ready_i    (b_ready_i),
    .csr_req_o    (wr_req),
    .grant_i      (wr_grant),
    .resp_valid_i (wr_resp_valid),
    .resp_i       (csr_resp)
  );

  axil_rd_path i_axil_rd_path (
    .clk_axi      (clk_axi),
    .arst_axi     (arst_axi),
    .ar_valid_i   (ar_valid_i),
    .ar_i         (ar_i),
    .ar_ready_o   (ar_ready_o),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .r_ready_i    (r_ready_i),
    .csr_req_o    (rd_req),
    .grant_i      (rd_grant),
    .resp_valid_i (rd_resp_valid),
    .resp_i       (csr_resp)
  );

  // one shared response bus, steered by the per-path valids.
  ni_csr_regs #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) i_ni_csr_regs (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .rd_req_i        (rd_req),
    .wr_req_i        (wr_req),
    .rd_grant_o      (rd_grant),
    .wr_grant_o      (wr_grant),
    .rd_resp_valid_o (rd_resp_valid),
    .wr_resp_valid_o (wr_resp_valid),
    .resp_o          (csr_resp),
    .vc_status_i     (vc_status_i),
    .irq_o           (irq_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the NI CSR testbench with Verilator and runs it from the project root.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module tb_ni_csr -o tb_ni_csr
./obj_dir/tb_ni_csr | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run finished, see sim.log"

//--- sim/tb_ni_csr.sv
// random AXI4-Lite traffic into the NI CSR block against a register model.
// built from vlog.f with tb_ni_csr as the top module.
`timescale 1ns/1ps
`default_nettype none

`include "ni_csr_cfg.svh"

module tb_ni_csr
  import axil_pkg::*;
  import ni_csr_pkg::*;
();

  localparam int NUM_OPS     = 400;
  localparam int CYCLE_LIMIT = NUM_OPS * 40;
  localparam logic [`NOC_ID_W-1:0] X_ID = 4'd5;
  localparam logic [`NOC_ID_W-1:0] Y_ID = 4'd9;
  localparam logic [`AXIL_ADDR_W-1:0] BASE = `CSR_BASE_ADDR;

  logic       clk_axi;
  logic       arst_axi;
  logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic       ar_valid, ar_ready, r_valid, r_ready;
  axil_aw_t   aw_beat;
  axil_w_t    w_beat;
  axil_b_t    b_beat;
  axil_ar_t   ar_beat;
  axil_r_t    r_beat;
  vc_status_t vc_status;
  ni_irq_t    irq;

  // model of the two writable registers.
  irq_src_e          src_m;
  logic [`AXIL_DATA_W-1:0] mask_m;
  int r_errs = 0;
  int b_errs = 0;
  int irq_errs = 0;
  int flag_errs = 0;
  int misc_errs = 0;
  int cycles = 0;

  ni_csr_top #(.ROUTER_X_ID(X_ID), .ROUTER_Y_ID(Y_ID)) i_ni_csr_top (
    .clk_axi (clk_axi), .arst_axi (arst_axi),
    .aw_valid_i (aw_valid), .aw_i (aw_beat), .aw_ready_o (aw_ready),
    .w_valid_i (w_valid), .w_i (w_beat), .w_ready_o (w_ready),
    .b_valid_o (b_valid), .b_o (b_beat), .b_ready_i (b_ready),
    .ar_valid_i (ar_valid), .ar_i (ar_beat), .ar_ready_o (ar_ready),
    .r_valid_o (r_valid), .r_o (r_beat), .r_ready_i (r_ready),
    .vc_status_i (vc_status), .irq_o (irq)
  );

  initial begin
    clk_axi = 1'b0;
    forever #4 clk_axi = ~clk_axi;
  end

  // hard stop if a response never shows up.
  always @(posedge clk_axi) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a response never arrived", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ********************************************************************
  // model
  // ********************************************************************
  function automatic ni_irq_t irq_model(input vc_status_t st);
    ni_irq_t q;
    q = '0;
    for (int i = 0; i < `NOC_NUM_VC; i++) begin
      case (src_m)
        IRQ_NOT_EMPTY:    q.irq_vcs[i] = ~st.empty[i];
        IRQ_EMPTY_MASKED: q.irq_vcs[i] = ~st.empty[i] & mask_m[i];
        IRQ_FULL_MASKED:  q.irq_vcs[i] = st.full[i] & mask_m[i];
        // threshold compare on the low mask bits.
        default:          q.irq_vcs[i] = (st.ocup[i] >= mask_m[`NOC_OCUP_W-1:0]);
      endcase
    end
    q.irq_trig = |q.irq_vcs;
    return q;
  endfunction

  function automatic axil_r_t model_read(input logic [`AXIL_ADDR_W-1:0] addr);
    axil_r_t e;
    ni_irq_t q;
    logic [`AXIL_ADDR_W-1:0] off;
    int idx;
    off = addr - BASE;
    idx = int'(off[5:2]);
    q = irq_model(vc_status);
    e.data = '0;
    e.resp = SLVERR;
    if (addr >= BASE && off < `CSR_WIN_BYTES && off[1:0] == 2'b00) begin
      e.resp = OKAY;
      // word index within the window.
      case (idx)
        0: e.data = `NOC_VERSION;
        1: e.data = `AXIL_DATA_W'(X_ID);
        2: e.data = `AXIL_DATA_W'(Y_ID);
        3: e.data = `AXIL_DATA_W'(q.irq_vcs);
        4: e.data = `AXIL_DATA_W'(src_m);
        5: e.data = mask_m;
        default: begin
          e.resp = SLVERR;
          for (int k = 0; k < `NOC_NUM_VC; k++) begin
            if (idx == 6 + k) begin
              e.data = `AXIL_DATA_W'(vc_status.pkt_size[k]);
              e.resp = OKAY;
            end
          end
        end
      endcase
    end
    return e;
  endfunction

  // updates the model and gives the expected B answer.
  task automatic model_write(input logic [`AXIL_ADDR_W-1:0] addr,
                             input logic [`AXIL_DATA_W-1:0] data, output axil_b_t exp);
    logic [`AXIL_ADDR_W-1:0] off;
    off = addr - BASE;
    exp.resp = SLVERR;
    if (addr >= BASE && off < `CSR_WIN_BYTES && off[1:0] == 2'b00) begin
      if (off == CSR_IRQ_SRC) begin
        src_m    = irq_src_e'(data[1:0]);
        exp.resp = OKAY;
      end else if (off == CSR_IRQ_MASK) begin
        mask_m   = data;
        exp.resp = OKAY;
      end
    end
  endtask

  // ********************************************************************
  // compare tasks
  // ********************************************************************
  task automatic check_r(input axil_r_t got, input axil_r_t exp);
    if (got !== exp) begin
      r_errs++;
      $display("[ERROR] t=%0t r_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_b(input axil_b_t got, input axil_b_t exp);
    if (got !== exp) begin
      b_errs++;
      $display("[ERROR] t=%0t b_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_irq(input ni_irq_t got, input ni_irq_t exp);
    if (got !== exp) begin
      irq_errs++;
      $display("[ERROR] t=%0t irq_o got %h expected %h", $time, got, exp);
    end
  endtask

  // single valid or ready output.
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ********************************************************************
  // channel drivers entered 1 ns after a rising edge
  // ********************************************************************
  // ready depends only on path state and is stable here.
  task automatic send_aw(input logic [`AXIL_ADDR_W-1:0] addr, input int skew);
    logic rdy;
    repeat (skew) begin
      @(posedge clk_axi);
      #1;
    end
    aw_beat.addr = addr;
    aw_valid     = 1'b1;
    do begin
      rdy = aw_ready;
      @(posedge clk_axi);
      #1;
    end while (!rdy);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [`AXIL_DATA_W-1:0] data, input int skew);
    logic rdy;
    repeat (skew) begin
      @(posedge clk_axi);
      #1;
    end
    w_beat.data = data;
    w_beat.strb = '1;
    w_valid     = 1'b1;
    do begin
      rdy = w_ready;
      @(posedge clk_axi);
      #1;
    end while (!rdy);
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input logic [`AXIL_ADDR_W-1:0] addr);
    logic rdy;
    ar_beat.addr = addr;
    ar_valid     = 1'b1;
    do begin
      rdy = ar_ready;
      @(posedge clk_axi);
      #1;
    end while (!rdy);
    ar_valid = 1'b0;
  endtask

  // bready held low about one cycle in three.
  task automatic take_b(input axil_b_t exp);
    logic done;
    done = 1'b0;
    while (!done) begin
      b_ready = ($urandom_range(0, 2) != 0);
      if (b_valid) begin
        // no new write is taken while B is pending.
        check_flag("aw_ready_o", aw_ready, 1'b0);
        check_flag("w_ready_o", w_ready, 1'b0);
      end
      if (b_valid && b_ready) begin
        check_b(b_beat, exp);
        done = 1'b1;
      end
      @(posedge clk_axi);
      #1;
    end
    b_ready = 1'b0;
  endtask

  task automatic take_r(input axil_r_t exp);
    logic done;
    done = 1'b0;
    while (!done) begin
      r_ready = ($urandom_range(0, 2) != 0);
      // no new read is taken while R is pending.
      if (r_valid) check_flag("ar_ready_o", ar_ready, 1'b0);
      if (r_valid && r_ready) begin
        check_r(r_beat, exp);
        done = 1'b1;
      end
      @(posedge clk_axi);
      #1;
    end
    r_ready = 1'b0;
  endtask

  // a read issued together with a write is granted first.
  task automatic run_op(input bit do_rd, input logic [`AXIL_ADDR_W-1:0] ra, input bit do_wr,
                        input logic [`AXIL_ADDR_W-1:0] wa, input logic [`AXIL_DATA_W-1:0] wd,
                        input int aw_skew, input int w_skew);
    axil_r_t exp_r;
    axil_b_t exp_b;
    exp_r      = model_read(ra);
    exp_b.resp = SLVERR;
    if (do_wr) model_write(wa, wd, exp_b);
    fork
      if (do_wr) send_aw(wa, aw_skew);
      if (do_wr) send_w(wd, w_skew);
      if (do_wr) take_b(exp_b);
      if (do_rd) send_ar(ra);
      if (do_rd) take_r(exp_r);
    join
    if (b_valid || r_valid) begin
      misc_errs++;
      $display("a response was still valid after its handshake at %0t", $time);
    end
  endtask

  function automatic logic [`AXIL_ADDR_W-1:0] pick_addr(input bit for_write);
    int sel;
    sel = int'($urandom_range(0, 9));
    // writes lean towards the two writable words.
    if (for_write && sel < 4) return (sel < 2) ? BASE + 16'h10 : BASE + 16'h14;
    if (sel < 7) return BASE + `AXIL_ADDR_W'(4 * $urandom_range(0, 15));
    if (sel == 7) return BASE + `AXIL_ADDR_W'($urandom_range(0, 63));
    if (sel == 8) return ($urandom_range(0, 1) != 0) ? BASE - 16'h4 : BASE + 16'h40;
    return `AXIL_ADDR_W'($urandom);
  endfunction

  task automatic randomize_status();
    for (int i = 0; i < `NOC_NUM_VC; i++) begin
      vc_status.empty[i]    = 1'($urandom_range(0, 1));
      vc_status.full[i]     = 1'($urandom_range(0, 1));
      vc_status.ocup[i]     = `NOC_OCUP_W'($urandom);
      vc_status.pkt_size[i] = `NOC_PKT_W'($urandom);
    end
  endtask

  // ********************************************************************
  // main sequence
  // ********************************************************************
  initial begin
    int kind;
    int aw_skew;
    int w_skew;
    int total;
    void'($urandom(97001));
    arst_axi  = 1'b1;
    aw_valid  = 1'b0;
    w_valid   = 1'b0;
    ar_valid  = 1'b0;
    b_ready   = 1'b0;
    r_ready   = 1'b0;
    aw_beat   = '0;
    w_beat    = '0;
    ar_beat   = '0;
    vc_status = '0;
    src_m     = IRQ_NOT_EMPTY;
    mask_m    = '1;
    repeat (8) @(posedge clk_axi);
    #1;
    arst_axi = 1'b0;
    @(posedge clk_axi);
    #1;
    check_irq(irq, irq_model(vc_status));
    // handshake outputs straight out of reset.
    check_flag("aw_ready_o", aw_ready, 1'b1);
    check_flag("w_ready_o", w_ready, 1'b1);
    check_flag("ar_ready_o", ar_ready, 1'b1);
    check_flag("b_valid_o", b_valid, 1'b0);
    check_flag("r_valid_o", r_valid, 1'b0);

    // reset values, constants and the first packet-size words.
    for (int k = 0; k < 8; k++) run_op(1'b1, BASE + `AXIL_ADDR_W'(4 * k), 1'b0, '0, '0, 0, 0);
    // source keeps two bits.
    run_op(1'b0, '0, 1'b1, BASE + 16'h10, 32'hffff_fffe, 0, 0);
    // read-only and unaligned accesses fail.
    run_op(1'b1, BASE + 16'h10, 1'b1, BASE + 16'h00, 32'h1234_5678, 0, 0);
    run_op(1'b1, BASE + 16'h01, 1'b1, BASE + 16'h14, 32'h0000_005a, 1, 0);
    run_op(1'b1, BASE + 16'h14, 1'b0, '0, '0, 0, 0);

    for (int n = 0; n < NUM_OPS; n++) begin
      randomize_status();
      @(posedge clk_axi);
      #1;
      check_irq(irq, irq_model(vc_status));
      kind    = int'($urandom_range(0, 2));
      aw_skew = (kind == 1) ? int'($urandom_range(0, 2)) : 0;
      w_skew  = (kind == 1) ? int'($urandom_range(0, 2)) : 0;
      run_op(kind != 1, pick_addr(1'b0), kind != 0, pick_addr(1'b1), $urandom, aw_skew, w_skew);
    end

    total = r_errs + b_errs + irq_errs + flag_errs + misc_errs;
    $display("errors: %0d total, r %0d, b %0d, irq %0d, flag %0d, other %0d",
             total, r_errs, b_errs, irq_errs, flag_errs, misc_errs);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/axil_pkg.sv
logic/ni_csr_pkg.sv
logic/axil_wr_path.sv
logic/axil_rd_path.sv
logic/ni_csr_regs.sv
logic/ni_csr_top.sv
sim/tb_ni_csr.sv
